// ==== Makefile ====
TOP = tb_psum_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

obj_dir/V$(TOP): project.f *.sv psum_cfg.svh
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== burst_queue.sv ====
`timescale 1ns/1ps
`include "psum_cfg.svh"

module burst_queue import psum_pkg::*; #(
    parameter type entry_type = psum_entry_t
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      in_req,
    input  entry_type in_entry,
    output logic      in_ack,
    input  logic      pop,
    output entry_type head,
    output logic      head_valid,
    output logic      empty
);
    localparam int depth = `PSUM_FIFO_DEPTH;
    localparam int ptr_w = $clog2(depth);

    entry_type        mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             full;
    logic             push;

    assign full  = (count == (ptr_w + 1)'(depth));
    assign empty = (count == '0);
    // ack still low means this req phase has not been stored yet
    assign push  = in_req && !in_ack && !full;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_ack     <= 1'b0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            head_valid <= 1'b0;
        end else begin
            if (push) begin
                in_ack <= 1'b1;
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end else if (!in_req) begin
                in_ack <= 1'b0;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            head_valid <= pop;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_entry;
        end
        if (pop) begin
            head <= mem[rd_ptr];
        end
    end

    pop_not_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("burst_queue: pop while empty");

    count_in_range: assert property (@(posedge clk) disable iff (rst) count <= depth)
        else $error("burst_queue: count above depth");

endmodule

// ==== fsum.sv ====
`timescale 1ns/1ps
`include "psum_cfg.svh"

module fsum import psum_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         empty,
    output logic         pop,
    input  psum_entry_t  head,
    input  logic         head_valid,
    input  psum_t        bias,
    output psum_t        a,
    output psum_t        b,
    output logic         nd,
    input  psum_t        sum,
    input  logic         rdy,
    output logic         res_req,
    output psum_result_t res,
    input  logic         res_ack
);
    localparam int lanes  = `PSUM_BURST_LEN;
    localparam int lane_w = $clog2(lanes);

    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_accum,
        st_emit,
        st_release
    } state_t;

    state_t            state;
    logic [lane_w-1:0] lane;
    psum_entry_t       ent;
    psum_t             fsum_buf [`PSUM_MAX_O_SIDE];
    psum_t             start_val;
    logic              take;
    logic              step;
    logic              last;

    assign take = (state == st_load) && head_valid;
    assign step = (state == st_accum) && rdy;
    assign last = (lane == lane_w'(lanes - 1));

    // channel 0 opens a new output from the bias, later channels continue it
    assign start_val = (head.channel == 8'd0) ? bias : fsum_buf[head.o_index];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= st_idle;
            pop     <= 1'b0;
            nd      <= 1'b0;
            res_req <= 1'b0;
            lane    <= '0;
        end else begin
            pop <= 1'b0;
            nd  <= 1'b0;
            case (state)
                st_idle: begin
                    if (!empty) begin
                        pop   <= 1'b1;
                        state <= st_load;
                    end
                end
                st_load: begin
                    if (head_valid) begin
                        nd    <= 1'b1;
                        lane  <= '0;
                        state <= st_accum;
                    end
                end
                st_accum: begin
                    if (rdy) begin
                        if (last) begin
                            res_req <= 1'b1;
                            state   <= st_emit;
                        end else begin
                            nd   <= 1'b1;
                            lane <= lane + 1'b1;
                        end
                    end
                end
                st_emit: begin
                    if (res_ack) begin
                        res_req <= 1'b0;
                        state   <= st_release;
                    end
                end
                st_release: begin
                    // hold off the next entry until the sink drops ack
                    if (!res_ack) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // operands, each sum goes back in as the next a
    always_ff @(posedge clk) begin
        if (take) begin
            ent <= head;
            a   <= start_val;
            b   <= head.data[0];
        end else if (step && !last) begin
            a <= sum;
            b <= ent.data[lane + 1'b1];
        end
        if (step && last) begin
            res.o_index <= ent.o_index;
            res.value   <= sum;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `PSUM_MAX_O_SIDE; i++) begin
                fsum_buf[i] <= '0;
            end
        end else if (step && last) begin
            fsum_buf[ent.o_index] <= sum;
        end
    end

    // one addition in flight, next nd only after the adder answers
    nd_one_outstanding: assert property (
        @(posedge clk) disable iff (rst) nd |=> (!nd throughout rdy[->1])
    ) else $error("fsum: nd while an addition is outstanding");

endmodule

// ==== project.f ====
+incdir+.
psum_pkg.sv
burst_queue.sv
sat_adder.sv
fsum.sv
psum_cfg_regs.sv
psum_top.sv
tb_psum_top.sv

// ==== psum_cfg.svh ====
`ifndef PSUM_CFG_SVH
`define PSUM_CFG_SVH

// output positions held in the full-sum buffer, index is clog2 of this
`define PSUM_MAX_O_SIDE 128

// lanes in one partial-sum burst
`define PSUM_BURST_LEN 8

// lane and result width
`define PSUM_LANE_W 16

// entries in the input queue
`define PSUM_FIFO_DEPTH 4

`endif

// ==== psum_cfg_regs.sv ====
`timescale 1ns/1ps

module psum_cfg_regs import psum_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cfg_req,
    input  cfg_write_t cfg_wr,
    output logic       cfg_ack,
    output psum_t      bias
);
    localparam logic [3:0] bias_addr = 4'd0;

    logic accept;

    // take the write once per req phase, on the edge that raises ack
    assign accept = cfg_req && !cfg_ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg_ack <= 1'b0;
            bias    <= '0;
        end else begin
            if (accept) begin
                cfg_ack <= 1'b1;
                if (cfg_wr.addr == bias_addr) begin
                    bias <= cfg_wr.wdata;
                end
            end else if (!cfg_req) begin
                cfg_ack <= 1'b0;
            end
        end
    end

    ack_after_req: assert property (
        @(posedge clk) disable iff (rst) $rose(cfg_ack) |-> $past(cfg_req)
    ) else $error("psum_cfg_regs: ack raised without req");

endmodule

// ==== psum_pkg.sv ====
`include "psum_cfg.svh"

package psum_pkg;

    // one lane of a burst, also the width of a full sum
    typedef logic signed [`PSUM_LANE_W-1:0] psum_t;

    typedef psum_t [`PSUM_BURST_LEN-1:0] burst_t;

    typedef logic [$clog2(`PSUM_MAX_O_SIDE)-1:0] o_index_t;

    // partial-sum burst as it leaves the multiply array
    typedef struct packed {
        o_index_t    o_index;
        logic [7:0]  channel;
        burst_t      data;
    } psum_entry_t;

    typedef struct packed {
        o_index_t    o_index;
        psum_t       value;
    } psum_result_t;

    // addr 0 is the bias, others are accepted and dropped
    typedef struct packed {
        logic [3:0]  addr;
        psum_t       wdata;
    } cfg_write_t;

endpackage

// ==== psum_top.sv ====
`timescale 1ns/1ps

module psum_top import psum_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         in_req,
    input  psum_entry_t  in_entry,
    output logic         in_ack,
    input  logic         cfg_req,
    input  cfg_write_t   cfg_wr,
    output logic         cfg_ack,
    output logic         res_req,
    output psum_result_t res,
    input  logic         res_ack
);
    psum_entry_t head;
    logic        head_valid;
    logic        empty;
    logic        pop;
    psum_t       bias;
    psum_t       add_a;
    psum_t       add_b;
    psum_t       add_sum;
    logic        add_nd;
    logic        add_rdy;

    burst_queue #(
        .entry_type (psum_entry_t)
    ) u_burst_queue (
        .clk        (clk),
        .rst        (rst),
        .in_req     (in_req),
        .in_entry   (in_entry),
        .in_ack     (in_ack),
        .pop        (pop),
        .head       (head),
        .head_valid (head_valid),
        .empty      (empty)
    );

    psum_cfg_regs u_psum_cfg_regs (
        .clk     (clk),
        .rst     (rst),
        .cfg_req (cfg_req),
        .cfg_wr  (cfg_wr),
        .cfg_ack (cfg_ack),
        .bias    (bias)
    );

    fsum u_fsum (
        .clk        (clk),
        .rst        (rst),
        .empty      (empty),
        .pop        (pop),
        .head       (head),
        .head_valid (head_valid),
        .bias       (bias),
        .a          (add_a),
        .b          (add_b),
        .nd         (add_nd),
        .sum        (add_sum),
        .rdy        (add_rdy),
        .res_req    (res_req),
        .res        (res),
        .res_ack    (res_ack)
    );

    sat_adder u_sat_adder (
        .clk (clk),
        .rst (rst),
        .a   (add_a),
        .b   (add_b),
        .nd  (add_nd),
        .sum (add_sum),
        .rdy (add_rdy)
    );

endmodule

// ==== sat_adder.sv ====
`timescale 1ns/1ps
`include "psum_cfg.svh"

module sat_adder import psum_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  psum_t a,
    input  psum_t b,
    input  logic  nd,
    output psum_t sum,
    output logic  rdy
);
    localparam int    lane_w  = `PSUM_LANE_W;
    localparam psum_t sat_max = {1'b0, {(lane_w - 1){1'b1}}};
    localparam psum_t sat_min = {1'b1, {(lane_w - 1){1'b0}}};

    logic [lane_w:0] wide_sum;
    logic [1:0]      vld;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld <= 2'b00;
        end else begin
            vld <= {vld[0], nd};
        end
    end

    // stage one, sign extended so overflow shows in the top two bits
    always_ff @(posedge clk) begin
        if (nd) begin
            wide_sum <= {a[lane_w-1], a} + {b[lane_w-1], b};
        end
    end

    // stage two, clamp
    always_ff @(posedge clk) begin
        if (vld[0]) begin
            if (wide_sum[lane_w] != wide_sum[lane_w-1]) begin
                sum <= wide_sum[lane_w] ? sat_min : sat_max;
            end else begin
                sum <= wide_sum[lane_w-1:0];
            end
        end
    end

    assign rdy = vld[1];

endmodule

// ==== tb_psum_top.sv ====
`timescale 1ns/1ps
`include "psum_cfg.svh"

module tb_psum_top import psum_pkg::*; ();
    localparam int n_phase     = 12;
    localparam int n_stall     = 6;
    localparam int n_entries   = 3 * n_phase + n_stall;
    localparam int watchdog_ns = (n_entries * 400 + 2000) * 100;

    logic         clk      = 1'b0;
    logic         rst      = 1'b1;
    logic         in_req   = 1'b0;
    psum_entry_t  in_entry = '0;
    logic         in_ack;
    logic         cfg_req  = 1'b0;
    cfg_write_t   cfg_wr   = '0;
    logic         cfg_ack;
    logic         res_req;
    psum_result_t res;
    logic         res_ack  = 1'b0;

    logic [31:0]  lfsr = 32'h8b87_4519;
    psum_t        model_buf [`PSUM_MAX_O_SIDE];
    psum_t        model_bias;
    psum_result_t exp_q [$];
    logic [7:0]   chan_next [`PSUM_MAX_O_SIDE];
    o_index_t     idx_set [4];
    logic         sink_hold    = 1'b0;

    psum_top u_psum_top (
        .clk      (clk),
        .rst      (rst),
        .in_req   (in_req),
        .in_entry (in_entry),
        .in_ack   (in_ack),
        .cfg_req  (cfg_req),
        .cfg_wr   (cfg_wr),
        .cfg_ack  (cfg_ack),
        .res_req  (res_req),
        .res      (res),
        .res_ack  (res_ack)
    );

    always #50 clk = ~clk;

    // fibonacci taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic psum_t sat_add(input psum_t x, input psum_t y);
        int s;
        s = int'(x) + int'(y);
        if (s > 32767) begin
            return psum_t'(32767);
        end
        if (s < -32768) begin
            return psum_t'(-32768);
        end
        return psum_t'(s);
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_result(input psum_result_t got, input psum_result_t exp);
        if (got.o_index !== exp.o_index || got.value !== exp.value) begin
            stop_run($sformatf("Fail at %0t ns: result index %0d value %0d, expected %0d %0d",
                               $time, got.o_index, got.value, exp.o_index, exp.value));
        end
    endtask

    task automatic check_ack_low(input logic ack, input string what);
        if (ack !== 1'b0) begin
            stop_run($sformatf("Fail at %0t ns: %s is high", $time, what));
        end
    endtask

    // channel 0 starts from the bias and later channels from the stored sum
    function automatic psum_result_t model_apply(input psum_entry_t e);
        psum_result_t r;
        psum_t        acc;
        acc = (e.channel == 8'd0) ? model_bias : model_buf[e.o_index];
        for (int i = 0; i < `PSUM_BURST_LEN; i++) begin
            acc = sat_add(acc, e.data[i]);
        end
        model_buf[e.o_index] = acc;
        r.o_index = e.o_index;
        r.value   = acc;
        return r;
    endfunction

    task automatic new_index_set();
        for (int i = 0; i < 4; i++) begin
            idx_set[i] = o_index_t'(rand_bits(7));
            chan_next[idx_set[i]] = 8'd0;
        end
    endtask

    // big lanes sit near full scale of either sign
    function automatic psum_entry_t make_entry(input logic big);
        psum_entry_t e;
        logic [1:0]  pick;
        logic [31:0] bits;
        pick = 2'(rand_bits(2));
        e.o_index = idx_set[pick];
        e.channel = chan_next[e.o_index];
        chan_next[e.o_index] = chan_next[e.o_index] + 8'd1;
        for (int i = 0; i < `PSUM_BURST_LEN; i++) begin
            if (big) begin
                bits = rand_bits(15);
                e.data[i] = {bits[14], ~bits[14], bits[13:0]};
            end else begin
                bits = rand_bits(10);
                e.data[i] = {{6{bits[9]}}, bits[9:0]};
            end
        end
        return e;
    endfunction

    task automatic send_entry(input psum_entry_t e, input logic stall_check);
        exp_q.push_back(model_apply(e));
        @(negedge clk);
        in_entry = e;
        in_req   = 1'b1;
        if (stall_check) begin
            repeat (40) begin
                @(negedge clk);
                check_ack_low(in_ack, "in_ack with the queue full");
            end
            sink_hold = 1'b0;
        end
        while (!in_ack) @(negedge clk);
        in_req = 1'b0;
        while (in_ack) @(negedge clk);
    endtask

    task automatic write_cfg(input logic [3:0] addr, input psum_t data);
        @(negedge clk);
        cfg_wr.addr  = addr;
        cfg_wr.wdata = data;
        cfg_req      = 1'b1;
        while (!cfg_ack) @(negedge clk);
        cfg_req = 1'b0;
        while (cfg_ack) @(negedge clk);
        if (addr == 4'd0) begin
            model_bias = data;
        end
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0 || res_req || res_ack) @(negedge clk);
    endtask

    task automatic run_phase(input int n, input logic big);
        new_index_set();
        repeat (n) send_entry(make_entry(big), 1'b0);
        wait_drained();
    endtask

    initial begin : sink
        int delay;
        forever begin
            @(negedge clk);
            if (res_req && !res_ack && !sink_hold) begin
                delay = int'(rand_bits(3));
                repeat (delay) @(negedge clk);
                if (exp_q.size() == 0) begin
                    stop_run("a result arrived with no entry outstanding");
                end else begin
                    check_result(res, exp_q.pop_front());
                    res_ack = 1'b1;
                    while (res_req) @(negedge clk);
                    res_ack = 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        stop_run("timeout: the results did not all arrive in time");
    end

    initial begin : main
        model_bias = '0;
        for (int i = 0; i < `PSUM_MAX_O_SIDE; i++) begin
            model_buf[i] = '0;
            chan_next[i] = 8'd0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (5) begin
            @(negedge clk);
            check_ack_low(in_ack, "in_ack after reset");
            check_ack_low(cfg_ack, "cfg_ack after reset");
            check_ack_low(res_req, "res_req after reset");
        end
        write_cfg(4'd0, psum_t'(rand_bits(12)));
        run_phase(n_phase, 1'b0);
        // near full-scale lanes push the sums into both clamps
        run_phase(n_phase, 1'b1);
        // new bias followed by a write to an unused address that must not change it
        write_cfg(4'd0, psum_t'(rand_bits(16)));
        write_cfg(4'd5, psum_t'(rand_bits(16)));
        run_phase(n_phase, 1'b0);
        // sink held so the engine stalls and the queue fills
        new_index_set();
        sink_hold = 1'b1;
        repeat (n_stall - 1) send_entry(make_entry(1'b0), 1'b0);
        send_entry(make_entry(1'b0), 1'b1);
        wait_drained();
        $display("Test passed");
        $finish;
    end

endmodule
